// File: include/l2_cfg.svh
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// associativity and way select width
`define L2_WAYS 4
`define L2_WAY_WIDTH 2

// set index bits
`define L2_INDEX_WIDTH 2
`define L2_SETS (1 << `L2_INDEX_WIDTH)

// word offset inside an L2 line
`define L2_OFFSET_WIDTH 3
`define L2_LINE_WORDS (1 << `L2_OFFSET_WIDTH)
`define L2_LINE_BITS (32 * `L2_LINE_WORDS)

// word offset inside an L1 line, half of an L2 line
`define L2_L1_OFFSET_WIDTH 2
`define L2_HALF_BITS (32 * (1 << `L2_L1_OFFSET_WIDTH))

// what is left of a 32-bit byte address
`define L2_TAG_WIDTH (32 - `L2_INDEX_WIDTH - `L2_OFFSET_WIDTH - 2)

`endif

// File: hdl/l2_pkg.sv
`include "l2_cfg.svh"

package l2_pkg;

    typedef logic [`L2_TAG_WIDTH-1:0]   l2_tag_t;
    typedef logic [`L2_INDEX_WIDTH-1:0] l2_index_t;
    typedef logic [`L2_WAY_WIDTH-1:0]   l2_way_t;

    typedef logic [`L2_LINE_BITS-1:0] l2_line_t;
    typedef logic [`L2_HALF_BITS-1:0] l2_half_t;

    typedef struct packed {
        l2_tag_t                     tag;
        l2_index_t                   index;
        logic [`L2_OFFSET_WIDTH-1:0] word;
        logic [1:0]                  byte_off;
    } l2_addr_fields_t;

    // same 32 bits, either whole or split
    typedef union packed {
        logic [31:0]     raw;
        l2_addr_fields_t f;
    } l2_addr_u;

    typedef enum logic {
        L2_SRC_ICACHE = 1'b0,
        L2_SRC_DCACHE = 1'b1
    } l2_src_e;

    typedef struct packed {
        logic        valid;
        l2_src_e     src;
        logic        wr;
        l2_addr_u    addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } l2_req_t;

    typedef struct packed {
        l2_req_t req;
        logic    hit;
        l2_way_t hit_way;
        l2_way_t victim_way;
        logic    victim_valid;
        l2_tag_t victim_tag;
    } l2_lookup_t;

    // tag array write from the refill
    typedef struct packed {
        logic      we;
        l2_index_t index;
        l2_way_t   way;
        l2_tag_t   tag;
    } l2_fill_t;

    typedef enum logic [2:0] {
        L2_IDLE,
        L2_WRITEBACK,
        L2_READ_REQ,
        L2_READ_WAIT,
        L2_INSTALL
    } l2_state_e;

endpackage

// File: hdl/l2_arbiter.sv
`timescale 1ns/1ps

module l2_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  logic            icache_req,
    input  logic [31:0]     icache_addr,
    input  logic            dcache_req,
    input  logic            dcache_wr,
    input  logic [31:0]     dcache_addr,
    input  logic [31:0]     dcache_wdata,
    input  logic [3:0]      dcache_wstrb,
    input  logic            ready,
    output logic            icache_addr_ok,
    output logic            dcache_addr_ok,
    output l2_pkg::l2_req_t req
);
    import l2_pkg::*;

    logic    can_accept;
    l2_req_t next_req;

    // buffer empty or moving on this edge
    assign can_accept = !req.valid || ready;

    // dcache wins when both ask
    assign dcache_addr_ok = can_accept && dcache_req;
    assign icache_addr_ok = can_accept && icache_req && !dcache_req;

    always_comb begin
        next_req = '0;
        if (dcache_req) begin
            next_req.valid    = 1'b1;
            next_req.src      = L2_SRC_DCACHE;
            next_req.wr       = dcache_wr;
            next_req.addr.raw = dcache_addr;
            next_req.wdata    = dcache_wdata;
            next_req.wstrb    = dcache_wstrb;
        end else if (icache_req) begin
            next_req.valid    = 1'b1;
            next_req.src      = L2_SRC_ICACHE;
            next_req.wr       = 1'b0;
            next_req.addr.raw = icache_addr;
        end
    end

    // request buffer, valid drops when nothing new arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else if (can_accept) begin
            req <= next_req;
        end
    end

endmodule

// File: hdl/l2_tag_lookup.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module l2_tag_lookup (
    input  logic               clk,
    input  logic               reset,
    input  l2_pkg::l2_req_t    in_req,
    input  logic               ready,
    input  l2_pkg::l2_fill_t   fill,
    output logic               in_ready,
    output l2_pkg::l2_lookup_t out
);
    import l2_pkg::*;

    l2_tag_t               tag_q   [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0]   valid_q [`L2_SETS];
    logic [`L2_WAYS-2:0]   plru_q  [`L2_SETS];

    l2_index_t             idx;
    l2_tag_t               req_tag;
    logic [`L2_WAYS-1:0]   fill_match;
    logic [`L2_WAYS-1:0]   set_valid;
    l2_tag_t               set_tag [`L2_WAYS];
    logic [`L2_WAYS-1:0]   hit_vec;
    logic                  hit;
    l2_way_t               hit_way;
    l2_way_t               plru_way;
    l2_way_t               victim_way;
    l2_way_t               touch_way;
    logic [`L2_WAYS-2:0]   plru_cur;
    logic [`L2_WAYS-2:0]   plru_next;

    assign idx     = in_req.addr.f.index;
    assign req_tag = in_req.addr.f.tag;

    assign in_ready = !out.req.valid || ready;

    // a fill landing this edge is forwarded so the waiting request sees it
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            fill_match[w] = fill.we && (fill.index == idx) && (fill.way == l2_way_t'(w));
            set_valid[w]  = valid_q[idx][w] || fill_match[w];
            set_tag[w]    = fill_match[w] ? fill.tag : tag_q[idx][w];
            hit_vec[w]    = set_valid[w] && (set_tag[w] == req_tag);
        end
    end

    assign hit = |hit_vec;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = l2_way_t'(w);
            end
        end
    end

    // tree plru, each bit points at the older half
    assign plru_cur = plru_q[idx];
    assign plru_way = plru_cur[0] ? {1'b1, plru_cur[2]} : {1'b0, plru_cur[1]};

    // lowest invalid way first
    always_comb begin
        victim_way = plru_way;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = l2_way_t'(w);
            end
        end
    end

    assign touch_way = hit ? hit_way : victim_way;

    always_comb begin
        plru_next    = plru_cur;
        plru_next[0] = ~touch_way[1];
        if (touch_way[1]) begin
            plru_next[2] = ~touch_way[0];
        end else begin
            plru_next[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.req.valid <= 1'b0;
        end else if (in_ready) begin
            out.req          <= in_req;
            out.hit          <= hit;
            out.hit_way      <= hit_way;
            out.victim_way   <= victim_way;
            out.victim_valid <= set_valid[victim_way];
            out.victim_tag   <= set_tag[victim_way];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (fill.we) begin
                valid_q[fill.index][fill.way] <= 1'b1;
            end
            if (in_req.valid && in_ready) begin
                plru_q[idx] <= plru_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.we) begin
            tag_q[fill.index][fill.way] <= fill.tag;
        end
    end

endmodule

// File: hdl/l2_data_stage.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module l2_data_stage (
    input  logic               clk,
    input  logic               reset,
    input  l2_pkg::l2_lookup_t in,
    input  logic               mem_addr_ok_r,
    input  logic               mem_addr_ok_w,
    input  logic               mem_data_ok,
    input  l2_pkg::l2_line_t   mem_rdata,
    output logic               in_ready,
    output l2_pkg::l2_fill_t   fill,
    output logic               icache_data_ok,
    output logic               dcache_data_ok,
    output l2_pkg::l2_half_t   icache_rdata,
    output l2_pkg::l2_half_t   dcache_rdata,
    output logic               mem_req_r,
    output logic [31:0]        mem_addr_r,
    output logic               mem_req_w,
    output logic [31:0]        mem_addr_w,
    output l2_pkg::l2_line_t   mem_wdata
);
    import l2_pkg::*;

    l2_line_t            data_q  [`L2_SETS][`L2_WAYS];
    logic [`L2_WAYS-1:0] dirty_q [`L2_SETS];

    l2_state_e           state;
    l2_state_e           state_next;
    l2_line_t            refill_q;
    l2_half_t            rdata_q;

    l2_index_t           idx;
    l2_way_t             cur_way;
    l2_line_t            cur_line;
    l2_line_t            base_line;
    l2_line_t            new_line;
    logic                respond;
    logic                install;

    // put one word into a line under its byte strobe
    function automatic l2_line_t merge_word(
        input l2_line_t                    line,
        input logic [`L2_OFFSET_WIDTH-1:0] word,
        input logic [31:0]                 wdata,
        input logic [3:0]                  wstrb
    );
        l2_line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[word * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

    assign idx      = in.req.addr.f.index;
    assign cur_way  = in.hit ? in.hit_way : in.victim_way;
    assign cur_line = data_q[idx][cur_way];
    assign install  = (state == L2_INSTALL);

    always_comb begin
        in_ready = 1'b0;
        case (state)
            L2_IDLE:    in_ready = !in.req.valid || in.hit;
            L2_INSTALL: in_ready = 1'b1;
            default:    in_ready = 1'b0;
        endcase
    end

    assign respond   = in_ready && in.req.valid;
    assign base_line = install ? refill_q : cur_line;
    assign new_line  = in.req.wr ?
                       merge_word(base_line, in.req.addr.f.word, in.req.wdata, in.req.wstrb) :
                       base_line;

    always_comb begin
        state_next = state;
        case (state)
            L2_IDLE: begin
                if (in.req.valid && !in.hit) begin
                    // dirty victim goes out before the refill
                    if (in.victim_valid && dirty_q[idx][in.victim_way]) begin
                        state_next = L2_WRITEBACK;
                    end else begin
                        state_next = L2_READ_REQ;
                    end
                end
            end
            L2_WRITEBACK: begin
                if (mem_addr_ok_w) begin
                    state_next = L2_READ_REQ;
                end
            end
            L2_READ_REQ: begin
                if (mem_addr_ok_r) begin
                    state_next = L2_READ_WAIT;
                end
            end
            L2_READ_WAIT: begin
                if (mem_data_ok) begin
                    state_next = L2_INSTALL;
                end
            end
            default: state_next = L2_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= L2_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // memory side, line aligned
    assign mem_req_w  = (state == L2_WRITEBACK);
    assign mem_addr_w = {in.victim_tag, idx, {(`L2_OFFSET_WIDTH + 2){1'b0}}};
    assign mem_wdata  = cur_line;
    assign mem_req_r  = (state == L2_READ_REQ);
    assign mem_addr_r = {in.req.addr.f.tag, idx, {(`L2_OFFSET_WIDTH + 2){1'b0}}};

    // tag update back to stage 2
    assign fill.we    = install;
    assign fill.index = idx;
    assign fill.way   = in.victim_way;
    assign fill.tag   = in.req.addr.f.tag;

    always_ff @(posedge clk) begin
        if (state == L2_READ_WAIT && mem_data_ok) begin
            refill_q <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (respond && (in.req.wr || install)) begin
            data_q[idx][cur_way] <= new_line;
        end
    end

    // refilled line is clean unless a write was waiting on it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                dirty_q[s] <= '0;
            end
        end else if (respond && install) begin
            dirty_q[idx][cur_way] <= in.req.wr;
        end else if (respond && in.req.wr) begin
            dirty_q[idx][cur_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            icache_data_ok <= 1'b0;
            dcache_data_ok <= 1'b0;
        end else begin
            icache_data_ok <= respond && (in.req.src == L2_SRC_ICACHE);
            dcache_data_ok <= respond && (in.req.src == L2_SRC_DCACHE);
        end
    end

    // top offset bit picks the half
    always_ff @(posedge clk) begin
        if (respond) begin
            if (in.req.addr.f.word[`L2_OFFSET_WIDTH-1]) begin
                rdata_q <= base_line[`L2_LINE_BITS-1 -: `L2_HALF_BITS];
            end else begin
                rdata_q <= base_line[`L2_HALF_BITS-1:0];
            end
        end
    end

    assign icache_rdata = rdata_q;
    assign dcache_rdata = rdata_q;

endmodule

// File: hdl/l2_cache.sv
`timescale 1ns/1ps

module l2_cache (
    input  logic             clk,
    input  logic             reset,

    input  logic             icache_req,
    input  logic [31:0]      icache_addr,
    output logic             icache_addr_ok,
    output logic             icache_data_ok,
    output l2_pkg::l2_half_t icache_rdata,

    input  logic             dcache_req,
    input  logic             dcache_wr,
    input  logic [31:0]      dcache_addr,
    input  logic [31:0]      dcache_wdata,
    input  logic [3:0]       dcache_wstrb,
    output logic             dcache_addr_ok,
    output logic             dcache_data_ok,
    output l2_pkg::l2_half_t dcache_rdata,

    output logic             mem_req_r,
    output logic [31:0]      mem_addr_r,
    input  logic             mem_addr_ok_r,
    input  logic             mem_data_ok,
    input  l2_pkg::l2_line_t mem_rdata,

    output logic             mem_req_w,
    output logic [31:0]      mem_addr_w,
    output l2_pkg::l2_line_t mem_wdata,
    input  logic             mem_addr_ok_w
);
    import l2_pkg::*;

    l2_req_t    s1_req;
    l2_lookup_t s2_out;
    l2_fill_t   fill;
    logic       s2_ready;
    logic       s3_ready;

    // stage 1
    l2_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_wstrb   (dcache_wstrb),
        .ready          (s2_ready),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .req            (s1_req)
    );

    // stage 2
    l2_tag_lookup u_tag_lookup (
        .clk      (clk),
        .reset    (reset),
        .in_req   (s1_req),
        .ready    (s3_ready),
        .fill     (fill),
        .in_ready (s2_ready),
        .out      (s2_out)
    );

    // stage 3
    l2_data_stage u_data_stage (
        .clk            (clk),
        .reset          (reset),
        .in             (s2_out),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .mem_rdata      (mem_rdata),
        .in_ready       (s3_ready),
        .fill           (fill),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok),
        .icache_rdata   (icache_rdata),
        .dcache_rdata   (dcache_rdata),
        .mem_req_r      (mem_req_r),
        .mem_addr_r     (mem_addr_r),
        .mem_req_w      (mem_req_w),
        .mem_addr_w     (mem_addr_w),
        .mem_wdata      (mem_wdata)
    );

endmodule

// File: testbench/l2_cache_monitor.sv
`timescale 1ns/1ps

module l2_cache_monitor (
    input logic         clk,
    input logic         reset,
    input logic         exp_hit,
    input logic         icache_req,
    input logic [31:0]  icache_addr,
    input logic         icache_addr_ok,
    input logic         icache_data_ok,
    input logic [127:0] icache_rdata,
    input logic         dcache_req,
    input logic         dcache_wr,
    input logic [31:0]  dcache_addr,
    input logic [31:0]  dcache_wdata,
    input logic [3:0]   dcache_wstrb,
    input logic         dcache_addr_ok,
    input logic         dcache_data_ok,
    input logic [127:0] dcache_rdata,
    input logic         mem_req_r,
    input logic [31:0]  mem_addr_r,
    input logic         mem_addr_ok_r,
    input logic         mem_req_w,
    input logic [31:0]  mem_addr_w,
    input logic [255:0] mem_wdata,
    input logic         mem_addr_ok_w
);
    typedef struct packed {
        logic        src;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        exp_hit;
        logic [31:0] cycle;
        logic [31:0] reads;
    } pending_t;

    int          errors = 0;
    logic [31:0] cycle = 0;
    logic [31:0] mem_reads = 0;
    logic        reset_q = 1'b1;
    pending_t    pend [$];
    logic [31:0] shadow [logic [31:0]];

    // memory contents before any write-back
    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return {a[15:0], ~a[31:16]} ^ (a * 32'h9e3779b1);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : pattern_word(a);
    endfunction

    task automatic fail(input string msg);
        $display("FAIL @%0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_response();
        pending_t    e;
        logic [31:0] base;
        logic [31:0] w;
        logic [127:0] got;
        logic [127:0] exp;
        if (pend.size() == 0) begin
            $display("error at %0t: data_ok with no request outstanding", $time);
            errors++;
            return;
        end
        e = pend.pop_front();
        if (e.src != dcache_data_ok) begin
            fail($sformatf("response for wrong requester, addr %h", e.addr));
        end
        if (e.wr) begin
            w = shadow_word({e.addr[31:2], 2'b00});
            for (int b = 0; b < 4; b++) begin
                if (e.wstrb[b]) begin
                    w[b*8 +: 8] = e.wdata[b*8 +: 8];
                end
            end
            shadow[{e.addr[31:2], 2'b00}] = w;
        end else begin
            base = {e.addr[31:4], 4'b0000};
            for (int i = 0; i < 4; i++) begin
                exp[i*32 +: 32] = shadow_word(base + 32'(i * 4));
            end
            got = e.src ? dcache_rdata : icache_rdata;
            if (got !== exp) begin
                fail($sformatf("read %h got %h expected %h", e.addr, got, exp));
            end
        end
        if (e.exp_hit && (cycle - e.cycle != 3)) begin
            fail($sformatf("hit %h took %0d cycles", e.addr, cycle - e.cycle));
        end
        if (e.exp_hit && (mem_reads != e.reads)) begin
            fail($sformatf("hit %h issued a memory read", e.addr));
        end
    endtask

    task automatic check_writeback();
        logic [31:0] exp;
        if (mem_addr_w[4:0] != 5'b0) begin
            fail($sformatf("write-back address %h not line aligned", mem_addr_w));
        end
        for (int i = 0; i < 8; i++) begin
            exp = shadow_word({mem_addr_w[31:5], 5'b0} + 32'(i * 4));
            if (mem_wdata[i*32 +: 32] !== exp) begin
                fail($sformatf("write-back %h word %0d got %h expected %h",
                               mem_addr_w, i, mem_wdata[i*32 +: 32], exp));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (reset_q && (icache_addr_ok || dcache_addr_ok || icache_data_ok
                            || dcache_data_ok || mem_req_r || mem_req_w)) begin
                fail("outputs not idle after reset");
            end
            if (dcache_req && icache_req && icache_addr_ok) begin
                fail("icache accepted while dcache was requesting");
            end
            if (mem_req_r && mem_addr_ok_r) begin
                if (mem_addr_r[4:0] != 5'b0) begin
                    fail($sformatf("read address %h not line aligned", mem_addr_r));
                end
                mem_reads++;
            end
            if (mem_req_w && mem_addr_ok_w) begin
                check_writeback();
            end
            if (icache_data_ok || dcache_data_ok) begin
                check_response();
            end
            if (dcache_req && dcache_addr_ok) begin
                pend.push_back({1'b1, dcache_wr, dcache_addr, dcache_wdata,
                                dcache_wstrb, exp_hit, cycle, mem_reads});
            end else if (icache_req && icache_addr_ok) begin
                pend.push_back({1'b0, 1'b0, icache_addr, 32'b0, 4'b0,
                                exp_hit, cycle, mem_reads});
            end
        end
        reset_q <= reset;
        cycle <= cycle + 1;
    end

endmodule

// File: testbench/l2_cache_checker.sv
`timescale 1ns/1ps

module l2_cache_checker (
    input logic        clk,
    input logic        reset,
    input logic        icache_req,
    input logic [31:0] icache_addr,
    input logic        icache_addr_ok,
    input logic        icache_data_ok,
    input logic        dcache_req,
    input logic        dcache_wr,
    input logic [31:0] dcache_addr,
    input logic [31:0] dcache_wdata,
    input logic [3:0]  dcache_wstrb,
    input logic        dcache_addr_ok,
    input logic        dcache_data_ok
);
    int errors = 0;

    // requester holds its request until accepted
    icache_hold: assert property (@(posedge clk) disable iff (reset)
        icache_req && !icache_addr_ok |=> icache_req && $stable(icache_addr))
        else begin
            $error("icache request dropped or changed before addr_ok");
            errors++;
        end

    dcache_hold: assert property (@(posedge clk) disable iff (reset)
        dcache_req && !dcache_addr_ok |=> dcache_req && $stable(dcache_wr)
            && $stable(dcache_addr) && $stable(dcache_wdata) && $stable(dcache_wstrb))
        else begin
            $error("dcache request dropped or changed before addr_ok");
            errors++;
        end

    icache_pulse: assert property (@(posedge clk) disable iff (reset)
        icache_data_ok |=> !icache_data_ok)
        else begin
            $error("icache_data_ok longer than one cycle");
            errors++;
        end

    dcache_pulse: assert property (@(posedge clk) disable iff (reset)
        dcache_data_ok |=> !dcache_data_ok)
        else begin
            $error("dcache_data_ok longer than one cycle");
            errors++;
        end

    one_grant: assert property (@(posedge clk) disable iff (reset)
        !(icache_addr_ok && dcache_addr_ok))
        else begin
            $error("both addr_ok high together");
            errors++;
        end

endmodule

bind l2_cache l2_cache_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .icache_req     (icache_req),
    .icache_addr    (icache_addr),
    .icache_addr_ok (icache_addr_ok),
    .icache_data_ok (icache_data_ok),
    .dcache_req     (dcache_req),
    .dcache_wr      (dcache_wr),
    .dcache_addr    (dcache_addr),
    .dcache_wdata   (dcache_wdata),
    .dcache_wstrb   (dcache_wstrb),
    .dcache_addr_ok (dcache_addr_ok),
    .dcache_data_ok (dcache_data_ok)
);

// File: testbench/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

    typedef struct packed {
        logic [1:0]  src;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] addr2;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        hit;
    } stim_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         exp_hit;
    logic         icache_req;
    logic [31:0]  icache_addr;
    logic         icache_addr_ok;
    logic         icache_data_ok;
    logic [127:0] icache_rdata;
    logic         dcache_req;
    logic         dcache_wr;
    logic [31:0]  dcache_addr;
    logic [31:0]  dcache_wdata;
    logic [3:0]   dcache_wstrb;
    logic         dcache_addr_ok;
    logic         dcache_data_ok;
    logic [127:0] dcache_rdata;
    logic         mem_req_r;
    logic [31:0]  mem_addr_r;
    logic         mem_addr_ok_r;
    logic         mem_data_ok;
    logic [255:0] mem_rdata;
    logic         mem_req_w;
    logic [31:0]  mem_addr_w;
    logic [255:0] mem_wdata;
    logic         mem_addr_ok_w;

    logic [31:0]  rng = 32'd3;
    logic         timed_out = 1'b0;
    logic [31:0]  mem_words [logic [31:0]];
    stim_t        stim [$];

    always #10 clk = ~clk;

    l2_cache uut (.*);

    l2_cache_monitor u_monitor (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], ~a[31:16]} ^ (a * 32'h9e3779b1);
    endfunction

    function automatic logic [255:0] read_line(input logic [31:0] a);
        logic [255:0] line;
        logic [31:0]  wa;
        for (int i = 0; i < 8; i++) begin
            wa = {a[31:5], 5'b0} + 32'(i * 4);
            line[i*32 +: 32] = mem_words.exists(wa) ? mem_words[wa] : init_word(wa);
        end
        return line;
    endfunction

    // memory read side with random accept and data delays
    always begin
        logic [31:0] a;
        @(posedge clk);
        #1;
        if (!reset && mem_req_r) begin
            rng = xorshift32(rng);
            repeat (rng % 3) begin
                @(posedge clk);
                #1;
            end
            a = mem_addr_r;
            mem_addr_ok_r = 1'b1;
            @(posedge clk);
            #1;
            mem_addr_ok_r = 1'b0;
            rng = xorshift32(rng);
            repeat (rng % 4) begin
                @(posedge clk);
                #1;
            end
            mem_rdata = read_line(a);
            mem_data_ok = 1'b1;
            @(posedge clk);
            #1;
            mem_data_ok = 1'b0;
        end
    end

    // memory write side stores the line when accepted
    always begin
        @(posedge clk);
        #1;
        if (!reset && mem_req_w) begin
            rng = xorshift32(rng);
            repeat (rng % 3) begin
                @(posedge clk);
                #1;
            end
            for (int i = 0; i < 8; i++) begin
                mem_words[{mem_addr_w[31:5], 5'b0} + 32'(i * 4)] = mem_wdata[i*32 +: 32];
            end
            mem_addr_ok_w = 1'b1;
            @(posedge clk);
            #1;
            mem_addr_ok_w = 1'b0;
        end
    end

    task automatic add_entry(input logic [1:0] src, input logic wr, input logic [31:0] addr,
                             input logic [31:0] addr2, input logic [31:0] wdata,
                             input logic [3:0] wstrb, input logic hit);
        stim.push_back({src, wr, addr, addr2, wdata, wstrb, hit});
    endtask

    // src is 0 for icache, 1 for dcache and 2 for both at once
    task automatic apply_entry(input stim_t s);
        logic d_wait;
        logic i_wait;
        logic d_acc;
        logic i_acc;
        int   n;
        exp_hit = s.hit;
        d_wait = (s.src != 2'd0);
        i_wait = (s.src != 2'd1);
        dcache_req = d_wait;
        dcache_wr = s.wr;
        dcache_addr = s.addr;
        dcache_wdata = s.wdata;
        dcache_wstrb = s.wstrb;
        icache_req = i_wait;
        icache_addr = (s.src == 2'd2) ? s.addr2 : s.addr;
        n = 0;
        while (!timed_out && (dcache_req || icache_req || d_wait || i_wait)) begin
            @(negedge clk);
            if (dcache_data_ok) begin
                d_wait = 1'b0;
            end
            if (icache_data_ok) begin
                i_wait = 1'b0;
            end
            d_acc = dcache_req && dcache_addr_ok;
            i_acc = icache_req && icache_addr_ok;
            @(posedge clk);
            #1;
            if (d_acc) begin
                dcache_req = 1'b0;
            end
            if (i_acc) begin
                icache_req = 1'b0;
            end
            n++;
            if (n > 300) begin
                $display("timeout waiting for addr_ok or data_ok on address %h", s.addr);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        exp_hit = 1'b0;
        icache_req = 1'b0;
        icache_addr = '0;
        dcache_req = 1'b0;
        dcache_wr = 1'b0;
        dcache_addr = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        mem_addr_ok_w = 1'b0;

        add_entry(2'd0, 1'b0, 32'h0000_1000, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd0, 1'b0, 32'h0000_1010, 32'h0, 32'h0, 4'h0, 1'b1);
        add_entry(2'd1, 1'b1, 32'h0000_1004, 32'h0, 32'hdead_beef, 4'b0101, 1'b1);
        add_entry(2'd1, 1'b0, 32'h0000_1004, 32'h0, 32'h0, 4'h0, 1'b1);
        add_entry(2'd1, 1'b1, 32'h0000_2048, 32'h0, 32'h1234_5678, 4'b1111, 1'b0);
        add_entry(2'd2, 1'b0, 32'h0000_2048, 32'h0000_3020, 32'h0, 4'h0, 1'b0);
        add_entry(2'd1, 1'b1, 32'h0000_1008, 32'h0, 32'hcafe_f00d, 4'b1100, 1'b1);
        // more lines in set 0 force the dirty line out
        add_entry(2'd1, 1'b0, 32'h0000_1080, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd0, 1'b0, 32'h0000_1100, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd1, 1'b0, 32'h0000_1180, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd0, 1'b0, 32'h0000_1200, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd1, 1'b0, 32'h0000_1280, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd1, 1'b0, 32'h0000_1008, 32'h0, 32'h0, 4'h0, 1'b0);
        add_entry(2'd1, 1'b0, 32'h0000_2048, 32'h0, 32'h0, 4'h0, 1'b1);

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        for (int i = 0; i < stim.size() && !timed_out; i++) begin
            apply_entry(stim[i]);
        end

        repeat (5) @(posedge clk);
        $display("errors: monitor %0d, assertions %0d",
                 u_monitor.errors, uut.u_checker.errors);
        if (!timed_out && u_monitor.errors == 0 && uut.u_checker.errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: l2_cache.f
+incdir+include
hdl/l2_pkg.sv
hdl/l2_arbiter.sv
hdl/l2_tag_lookup.sv
hdl/l2_data_stage.sv
hdl/l2_cache.sv
testbench/l2_cache_monitor.sv
testbench/l2_cache_checker.sv
testbench/l2_cache_tb.sv

// File: Makefile
SIM      = verilator
TOP      = l2_cache_tb
FILELIST = l2_cache.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) include/l2_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
